/* Bender.yml */
package:
  name: serv_lite

sources:
  - logic/serv_lite_pkg.sv
  - logic/fetch_unit.sv
  - logic/insn_decode.sv
  - logic/serial_sequencer.sv
  - logic/serial_alu.sv
  - logic/serial_regfile.sv
  - logic/serv_lite_top.sv
  - target: test
    files:
      - test/tb_serv_lite.sv

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_start,
   input  logic                           i_pc_advance,
   output logic                           o_ibus_req,
   output logic [serv_lite_pkg::XLEN-1:0] o_ibus_adr,
   input  logic                           i_ibus_ack,
   input  logic [serv_lite_pkg::XLEN-1:0] i_ibus_rdt,
   output logic [serv_lite_pkg::XLEN-1:0] o_insn,
   output logic                           o_insn_valid,
   output logic [serv_lite_pkg::XLEN-1:0] o_pc,
   output logic                           o_done
);
   import serv_lite_pkg::*;

   typedef enum logic [1:0] {
      F_IDLE,
      F_REQ,
      F_ACK_LOW
   } fetch_state_e;

   fetch_state_e    state;
   logic [XLEN-1:0] pc;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc <= RESET_PC;
      end else if (i_pc_advance) begin
         pc <= pc + PC_STEP;
      end
   end

   // Comes out of reset already requesting
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state        <= F_REQ;
         o_insn_valid <= 1'b0;
      end else begin
         o_insn_valid <= 1'b0;
         case (state)
            F_IDLE: begin
               if (i_start)
                  state <= F_REQ;
            end
            F_REQ: begin
               if (i_ibus_ack) begin
                  state        <= F_ACK_LOW;
                  o_insn_valid <= 1'b1;
               end
            end
            F_ACK_LOW: begin
               if (!i_ibus_ack)
                  state <= F_IDLE;
            end
            default: state <= F_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == F_REQ && i_ibus_ack)
         o_insn <= i_ibus_rdt;
   end

   assign o_ibus_req = (state == F_REQ);
   assign o_ibus_adr = pc;
   assign o_pc       = pc;
   // Fetch ends when the memory has released ack
   assign o_done     = (state == F_ACK_LOW) && !i_ibus_ack;

endmodule

/* logic/insn_decode.sv */
`timescale 1ns/1ps

module insn_decode (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic [serv_lite_pkg::XLEN-1:0] i_insn,
   input  logic                           i_insn_valid,
   output serv_lite_pkg::decode_t         o_dec
);
   import serv_lite_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       f3_ok;
   alu_op_e    f3_op;
   decode_t    dec_d;

   assign opcode = i_insn[6:0];
   assign funct3 = i_insn[14:12];
   assign funct7 = i_insn[31:25];

   // funct3 is shared between the register and immediate forms
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  f3_op = ALU_ADD;
         3'b100:  f3_op = ALU_XOR;
         3'b110:  f3_op = ALU_OR;
         3'b111:  f3_op = ALU_AND;
         default: begin
            f3_op = ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      dec_d     = '0;
      dec_d.rd  = i_insn[11:7];
      dec_d.rs1 = i_insn[19:15];
      dec_d.rs2 = i_insn[24:20];
      dec_d.op  = f3_op;
      case (opcode)
         OPC_OP: begin
            dec_d.sub   = (funct7 == F7_SUB);
            // Only ADD may carry the SUB variant of funct7
            dec_d.valid = f3_ok &&
                          ((funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == 3'b000));
         end
         OPC_OP_IMM: begin
            dec_d.valid   = f3_ok;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {{20{i_insn[31]}}, i_insn[31:20]};
         end
         OPC_LUI: begin
            dec_d.valid   = 1'b1;
            dec_d.use_imm = 1'b1;
            dec_d.is_lui  = 1'b1;
            dec_d.op      = ALU_ADD;
            dec_d.imm     = {i_insn[31:12], 12'h000};
         end
         default: dec_d.valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_dec <= '0;
      end else if (i_insn_valid) begin
         o_dec <= dec_d;
      end
   end

endmodule

/* logic/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_en,
   input  logic                   i_first,
   input  serv_lite_pkg::decode_t i_dec,
   input  logic                   i_rs1_bit,
   input  logic                   i_rs2_bit,
   input  logic                   i_imm_bit,
   output logic                   o_rd_bit
);
   import serv_lite_pkg::*;

   logic op_a;
   logic op_b;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_out;

   // LUI adds the immediate to zero
   assign op_a = i_dec.is_lui ? 1'b0 : i_rs1_bit;
   assign op_b = (i_dec.use_imm ? i_imm_bit : i_rs2_bit) ^ i_dec.sub;

   // Subtract is A + ~B + 1, so the carry seeds with sub
   assign carry_in  = i_first ? i_dec.sub : carry_q;
   assign sum       = op_a ^ op_b ^ carry_in;
   assign carry_out = (op_a & op_b) | (carry_in & (op_a ^ op_b));

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (i_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_dec.op)
         ALU_ADD: o_rd_bit = sum;
         ALU_XOR: o_rd_bit = op_a ^ op_b;
         ALU_OR:  o_rd_bit = op_a | op_b;
         ALU_AND: o_rd_bit = op_a & op_b;
         default: o_rd_bit = sum;
      endcase
   end

endmodule

/* logic/serial_regfile.sv */
`timescale 1ns/1ps

module serial_regfile (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_en,
   input  logic                           i_first,
   input  serv_lite_pkg::decode_t         i_dec,
   input  logic                           i_rd_bit,
   input  logic [serv_lite_pkg::XLEN-1:0] i_pc,
   output logic                           o_rs1_bit,
   output logic                           o_rs2_bit,
   output logic                           o_imm_bit,
   input  logic                           i_ret_start,
   output logic                           o_ret_req,
   output serv_lite_pkg::retire_t         o_ret,
   input  logic                           i_ret_ack,
   output logic                           o_ret_done
);
   import serv_lite_pkg::*;

   typedef enum logic [1:0] {
      R_IDLE,
      R_REQ,
      R_ACK_LOW
   } ret_state_e;

   logic [XLEN-1:0] rf [2**REG_AW];
   logic [XLEN-1:0] rs1_sh;
   logic [XLEN-1:0] rs2_sh;
   logic [XLEN-1:0] imm_sh;
   logic [XLEN-1:0] rd_sh;
   logic            en_q;
   ret_state_e      rstate;

   // Bit 0 comes straight from the source, later bits from the shift copies
   assign o_rs1_bit = i_first ? rf[i_dec.rs1][0] : rs1_sh[0];
   assign o_rs2_bit = i_first ? rf[i_dec.rs2][0] : rs2_sh[0];
   assign o_imm_bit = i_first ? i_dec.imm[0] : imm_sh[0];

   always_ff @(posedge clk) begin
      if (i_en) begin
         if (i_first) begin
            rs1_sh <= rf[i_dec.rs1] >> 1;
            rs2_sh <= rf[i_dec.rs2] >> 1;
            imm_sh <= i_dec.imm >> 1;
         end else begin
            rs1_sh <= rs1_sh >> 1;
            rs2_sh <= rs2_sh >> 1;
            imm_sh <= imm_sh >> 1;
         end
         // Result enters at the MSB, so bit 0 ends up at the bottom
         rd_sh <= {i_rd_bit, rd_sh[XLEN-1:1]};
      end
   end

   // Commit once the final bit is in, i.e. when exec_en drops
   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < 2**REG_AW; i++)
            rf[i] <= '0;
         en_q <= 1'b0;
      end else begin
         en_q <= i_en;
         if (en_q && !i_en && i_dec.rd != '0)
            rf[i_dec.rd] <= rd_sh;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         rstate <= R_IDLE;
      end else begin
         case (rstate)
            R_IDLE: begin
               if (i_ret_start)
                  rstate <= R_REQ;
            end
            R_REQ: begin
               if (i_ret_ack)
                  rstate <= R_ACK_LOW;
            end
            R_ACK_LOW: begin
               if (!i_ret_ack)
                  rstate <= R_IDLE;
            end
            default: rstate <= R_IDLE;
         endcase
      end
   end

   // Held for the whole request
   always_ff @(posedge clk) begin
      if (rstate == R_IDLE && i_ret_start)
         o_ret <= '{pc: i_pc, rd: i_dec.rd, value: rd_sh};
   end

   assign o_ret_req  = (rstate == R_REQ);
   assign o_ret_done = (rstate == R_ACK_LOW) && !i_ret_ack;

endmodule

/* logic/serial_sequencer.sv */
`timescale 1ns/1ps

module serial_sequencer (
   input  logic                   clk,
   input  logic                   i_rst,
   input  serv_lite_pkg::decode_t i_dec,
   input  logic                   i_fetch_done,
   input  logic                   i_ret_done,
   output logic                   o_fetch_start,
   output logic                   o_exec_en,
   output logic                   o_bit_first,
   output logic                   o_ret_start,
   output logic                   o_pc_advance
);
   import serv_lite_pkg::*;

   typedef enum logic [1:0] {
      S_FETCH,
      S_DECODE,
      S_EXEC,
      S_RETIRE
   } seq_state_e;

   seq_state_e       state;
   logic [CNT_W-1:0] cnt;
   logic             next_fetch;

   // Skipped encodings and writes to x0 go straight back to fetch
   always_comb begin
      case (state)
         S_DECODE: next_fetch = !i_dec.valid || (i_dec.rd == '0);
         S_RETIRE: next_fetch = i_ret_done;
         default:  next_fetch = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state       <= S_FETCH;
         cnt         <= '0;
         o_ret_start <= 1'b0;
      end else begin
         o_ret_start <= 1'b0;
         case (state)
            S_FETCH: begin
               if (i_fetch_done)
                  state <= S_DECODE;
            end
            S_DECODE: begin
               cnt   <= '0;
               state <= next_fetch ? S_FETCH : S_EXEC;
            end
            S_EXEC: begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(XLEN - 1)) begin
                  state       <= S_RETIRE;
                  o_ret_start <= 1'b1;
               end
            end
            S_RETIRE: begin
               if (next_fetch)
                  state <= S_FETCH;
            end
            default: state <= S_FETCH;
         endcase
      end
   end

   assign o_exec_en     = (state == S_EXEC);
   assign o_bit_first   = (state == S_EXEC) && (cnt == '0);
   assign o_fetch_start = next_fetch;
   assign o_pc_advance  = next_fetch;

endmodule

/* logic/serv_lite_pkg.sv */
package serv_lite_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = $clog2(XLEN);

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
   localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

   // Major opcodes in the supported subset
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_XOR = 2'd1,
      ALU_OR  = 2'd2,
      ALU_AND = 2'd3
   } alu_op_e;

   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic              use_imm;
      logic              is_lui;
      logic              sub;
      alu_op_e           op;
      logic [XLEN-1:0]   imm;
   } decode_t;

   typedef struct packed {
      logic [XLEN-1:0]   pc;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   value;
   } retire_t;

endpackage

/* logic/serv_lite_top.sv */
`timescale 1ns/1ps

module serv_lite_top (
   input  logic                           clk,
   input  logic                           i_rst,
   output logic                           o_ibus_req,
   output logic [serv_lite_pkg::XLEN-1:0] o_ibus_adr,
   input  logic                           i_ibus_ack,
   input  logic [serv_lite_pkg::XLEN-1:0] i_ibus_rdt,
   output logic                           o_ret_req,
   output serv_lite_pkg::retire_t         o_ret,
   input  logic                           i_ret_ack
);
   import serv_lite_pkg::*;

   logic [XLEN-1:0] insn;
   logic [XLEN-1:0] pc;
   logic            insn_valid;
   logic            fetch_done;
   logic            fetch_start;
   logic            pc_advance;
   decode_t         dec;
   logic            exec_en;
   logic            bit_first;
   logic            ret_start;
   logic            ret_done;
   logic            rs1_bit;
   logic            rs2_bit;
   logic            imm_bit;
   logic            rd_bit;

   fetch_unit u_fetch (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_start      (fetch_start),
      .i_pc_advance (pc_advance),
      .o_ibus_req   (o_ibus_req),
      .o_ibus_adr   (o_ibus_adr),
      .i_ibus_ack   (i_ibus_ack),
      .i_ibus_rdt   (i_ibus_rdt),
      .o_insn       (insn),
      .o_insn_valid (insn_valid),
      .o_pc         (pc),
      .o_done       (fetch_done)
   );

   insn_decode u_decode (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_insn       (insn),
      .i_insn_valid (insn_valid),
      .o_dec        (dec)
   );

   serial_sequencer u_seq (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_dec         (dec),
      .i_fetch_done  (fetch_done),
      .i_ret_done    (ret_done),
      .o_fetch_start (fetch_start),
      .o_exec_en     (exec_en),
      .o_bit_first   (bit_first),
      .o_ret_start   (ret_start),
      .o_pc_advance  (pc_advance)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_en      (exec_en),
      .i_first   (bit_first),
      .i_dec     (dec),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit)
   );

   serial_regfile u_rf (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_en        (exec_en),
      .i_first     (bit_first),
      .i_dec       (dec),
      .i_rd_bit    (rd_bit),
      .i_pc        (pc),
      .o_rs1_bit   (rs1_bit),
      .o_rs2_bit   (rs2_bit),
      .o_imm_bit   (imm_bit),
      .i_ret_start (ret_start),
      .o_ret_req   (o_ret_req),
      .o_ret       (o_ret),
      .i_ret_ack   (i_ret_ack),
      .o_ret_done  (ret_done)
   );

endmodule

/* sim.f */
logic/serv_lite_pkg.sv
logic/fetch_unit.sv
logic/insn_decode.sv
logic/serial_sequencer.sv
logic/serial_alu.sv
logic/serial_regfile.sv
logic/serv_lite_top.sv
test/tb_serv_lite.sv

/* test/tb_serv_lite.sv */
`timescale 1ns/1ps

module tb_serv_lite;
   import serv_lite_pkg::*;

   localparam int N_INSN     = 43;
   localparam int MAX_CYCLES = 200 * N_INSN + 10;

   typedef enum logic [2:0] {K_ADD, K_SUB, K_XOR, K_OR, K_AND} op_kind_e;

   logic            clk;
   logic            i_rst;
   logic            o_ibus_req;
   logic [XLEN-1:0] o_ibus_adr;
   logic            i_ibus_ack;
   logic [XLEN-1:0] i_ibus_rdt;
   logic            o_ret_req;
   retire_t         o_ret;
   logic            i_ret_ack;

   logic [XLEN-1:0] prog [N_INSN];
   logic [XLEN-1:0] regs [32];
   logic [XLEN-1:0] exp_pc;
   int              n_issued;
   int              cycles = 0;

   serv_lite_top UUT (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_req (o_ibus_req),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_ret_req  (o_ret_req),
      .o_ret      (o_ret),
      .i_ret_ack  (i_ret_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
         fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
   end

   // Sample and drive just after the edge, where outputs have settled
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_adr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH o_ibus_adr: got %h expected %h", got, exp));
   endtask

   task automatic check_retire(input retire_t got, input retire_t exp);
      if (got !== exp)
         fail_run($sformatf(
            "MISMATCH o_ret: got pc=%h rd=%h value=%h expected pc=%h rd=%h value=%h",
            got.pc, got.rd, got.value, exp.pc, exp.rd, exp.value));
   endtask

   // A retire showing up here belongs to an instruction that should not retire
   task automatic await_fetch(input logic [XLEN-1:0] adr);
      while (!o_ibus_req) begin
         if (o_ret_req)
            fail_run("Retire request seen for an instruction that must not retire");
         next_cycle();
      end
      check_adr(o_ibus_adr, adr);
   endtask

   task automatic serve_fetch(input logic [XLEN-1:0] adr);
      await_fetch(adr);
      repeat ($urandom_range(3)) next_cycle();
      i_ibus_ack = 1'b1;
      i_ibus_rdt = prog[(o_ibus_adr - RESET_PC) >> 2];
      next_cycle();
      while (o_ibus_req)
         next_cycle();
      repeat ($urandom_range(3)) next_cycle();
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
   endtask

   task automatic serve_retire(input retire_t exp);
      while (!o_ret_req) begin
         if (o_ibus_req)
            fail_run("Next fetch started before the expected retire");
         next_cycle();
      end
      check_retire(o_ret, exp);
      repeat ($urandom_range(3)) next_cycle();
      i_ret_ack = 1'b1;
      next_cycle();
      while (o_ret_req)
         next_cycle();
      repeat ($urandom_range(3)) next_cycle();
      i_ret_ack = 1'b0;
   endtask

   // One instruction from fetch to retire; x0 and skipped encodings do not retire
   task automatic run_insn(input logic [XLEN-1:0] insn, input bit valid,
                           input logic [4:0] rd, input logic [XLEN-1:0] value);
      retire_t exp;
      if (n_issued >= N_INSN)
         fail_run("Program is longer than N_INSN");
      prog[n_issued] = insn;
      serve_fetch(exp_pc);
      if (valid && rd != 5'd0) begin
         exp = '{pc: exp_pc, rd: rd, value: value};
         serve_retire(exp);
         regs[rd] = value;
      end
      exp_pc   = exp_pc + PC_STEP;
      n_issued = n_issued + 1;
   endtask

   function automatic logic [2:0] funct3_of(input op_kind_e k);
      case (k)
         K_XOR:   return 3'b100;
         K_OR:    return 3'b110;
         K_AND:   return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

   function automatic logic [XLEN-1:0] alu_ref(input op_kind_e k,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
      case (k)
         K_SUB:   return a - b;
         K_XOR:   return a ^ b;
         K_OR:    return a | b;
         K_AND:   return a & b;
         default: return a + b;
      endcase
   endfunction

   function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   task automatic op_reg(input op_kind_e k, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
      logic [6:0] f7;
      f7 = (k == K_SUB) ? 7'b0100000 : 7'b0000000;
      run_insn(enc_r(f7, rs2, rs1, funct3_of(k), rd), 1'b1, rd,
               alu_ref(k, regs[rs1], regs[rs2]));
   endtask

   task automatic op_imm(input op_kind_e k, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
      run_insn({imm, rs1, funct3_of(k), rd, 7'b0010011}, 1'b1, rd,
               alu_ref(k, regs[rs1], {{20{imm[11]}}, imm}));
   endtask

   task automatic op_lui(input logic [4:0] rd, input logic [19:0] imm);
      run_insn({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'h000});
   endtask

   task automatic test_imm_forms();
      op_imm(K_ADD, 5'd1, 5'd0, 12'd5);
      op_imm(K_ADD, 5'd2, 5'd0, 12'hffd);
      op_imm(K_ADD, 5'd3, 5'd1, 12'hff9);
      op_imm(K_XOR, 5'd4, 5'd2, 12'h0f0);
      op_imm(K_OR,  5'd5, 5'd1, 12'hf00);
      op_imm(K_AND, 5'd6, 5'd2, 12'h7ff);
      op_imm(K_AND, 5'd7, 5'd4, 12'hff0);
   endtask

   task automatic test_lui();
      op_lui(5'd8, 20'h12345);
      op_lui(5'd9, 20'hfffff);
      op_imm(K_ADD, 5'd8, 5'd8, 12'h678);
   endtask

   task automatic test_reg_forms();
      op_reg(K_ADD, 5'd10, 5'd8, 5'd9);
      // Both of these wrap below zero
      op_reg(K_SUB, 5'd11, 5'd1, 5'd8);
      op_reg(K_SUB, 5'd12, 5'd0, 5'd1);
      op_reg(K_AND, 5'd13, 5'd8, 5'd4);
      op_reg(K_OR,  5'd14, 5'd1, 5'd6);
      op_reg(K_XOR, 5'd15, 5'd8, 5'd9);
      op_reg(K_ADD, 5'd16, 5'd2, 5'd2);
      op_reg(K_SUB, 5'd17, 5'd16, 5'd16);
   endtask

   task automatic test_x0_and_skip();
      op_imm(K_ADD, 5'd0, 5'd1, 12'd99);
      op_reg(K_ADD, 5'd0, 5'd8, 5'd9);
      op_reg(K_ADD, 5'd18, 5'd0, 5'd1);
      // SLT, BEQ, SUB-style AND and an all-zero word
      run_insn(enc_r(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd19), 1'b0, 5'd19, '0);
      run_insn(32'h0020_8063, 1'b0, 5'd0, '0);
      run_insn(enc_r(7'b0100000, 5'd2, 5'd1, 3'b111, 5'd19), 1'b0, 5'd19, '0);
      run_insn(32'h0000_0000, 1'b0, 5'd0, '0);
      op_reg(K_ADD, 5'd20, 5'd19, 5'd0);
      op_imm(K_XOR, 5'd21, 5'd0, 12'h555);
   endtask

   task automatic test_mixed_stream();
      int          sel;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [19:0] imm;
      for (int n = 0; n < 16; n++) begin
         sel = $urandom_range(9);
         rd  = 5'($urandom_range(31));
         rs1 = 5'($urandom_range(31));
         rs2 = 5'($urandom_range(31));
         imm = 20'($urandom);
         case (sel)
            5:       op_imm(K_ADD, rd, rs1, imm[11:0]);
            6:       op_imm(K_XOR, rd, rs1, imm[11:0]);
            7:       op_imm(K_OR, rd, rs1, imm[11:0]);
            8:       op_imm(K_AND, rd, rs1, imm[11:0]);
            9:       op_lui(rd, imm);
            default: op_reg(op_kind_e'(sel), rd, rs1, rs2);
         endcase
      end
   endtask

   initial begin
      void'($urandom(32'h0c2d_520d));
      i_rst      = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      i_ret_ack  = 1'b0;
      exp_pc     = RESET_PC;
      n_issued   = 0;
      for (int i = 0; i < 32; i++)
         regs[i] = '0;
      repeat (3) @(posedge clk);
      #1;
      i_rst = 1'b0;
      if (o_ret_req)
         fail_run("Retire request is high right after reset");
      if (!o_ibus_req)
         fail_run("Fetch request is not high right after reset");
      test_imm_forms();
      test_lui();
      test_reg_forms();
      test_x0_and_skip();
      test_mixed_stream();
      // Last instruction must be followed by a fetch at the next address
      await_fetch(exp_pc);
      $display("TEST OK");
      $finish;
   end

endmodule
